/* include/kbd_config.svh */
//**************************************************************************
// build-time parameters of the PS/2 keyboard controller
//**************************************************************************

`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// scan-code fifo holds 2**KBD_FIFO_LOG2 entries
`define KBD_FIFO_LOG2 3

// consecutive equal samples before a filtered ps2 line may change
`define KBD_FILTER_LEN 4

// processor bus data width
`define KBD_DATA_W 8

`endif

/* hdl/kbd_pkg.sv */
//**************************************************************************
// kbd_pkg: shared types of the keyboard controller
//**************************************************************************

`default_nettype none

`include "kbd_config.svh"

package kbd_pkg;

  typedef logic [7:0] scan_code_t;                    // one keyboard scan code

  typedef logic [`KBD_DATA_W-1:0] bus_data_t;         // one cpu bus word

  typedef logic [`KBD_FIFO_LOG2:0] fifo_count_t;      // 0 .. depth inclusive

  // receiver frame position, advanced on falling ps2 clock
  typedef enum logic [1:0] {
    ST_IDLE,                                          // waiting for start bit
    ST_DATA,                                          // eight data bits
    ST_PARITY,                                        // odd parity bit
    ST_STOP                                           // stop bit, must be high
  } ps2_state_e;

endpackage

`default_nettype wire

/* hdl/scan_fifo_if.sv */
//**************************************************************************
// scan_fifo_if: fifo read side and overflow control
//**************************************************************************

`default_nettype none

interface scan_fifo_if;
  import kbd_pkg::*;

  scan_code_t code;        // oldest entry, valid while not_empty
  logic       not_empty;
  logic       pop;         // drop oldest entry at next edge
  logic       overflow;    // sticky, a code was lost
  logic       clear_ovf;   // one-cycle clear of overflow

  modport producer (output code, output not_empty, output overflow,
                    input pop, input clear_ovf);
  modport consumer (input code, input not_empty, input overflow,
                    output pop, output clear_ovf);

endinterface

`default_nettype wire

/* hdl/ps2_rx.sv */
//**************************************************************************
// PS/2 line synchronizer and glitch filter
// frame receiver that yields one scan code per good 11-bit frame
//**************************************************************************

`default_nettype none

`include "kbd_config.svh"

module ps2_rx (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 ps2_clk,
  input  wire                 ps2_data,
  output logic                code_valid,
  output kbd_pkg::scan_code_t code,
  output logic                frame_err
);
  import kbd_pkg::*;

  localparam int FLT_W = $clog2(`KBD_FILTER_LEN + 1);
  localparam int LN_CLK = 0;   // line index of ps2 clock
  localparam int LN_DAT = 1;   // line index of ps2 data

  logic [1:0]       sync_a;      // first synchronizer stage
  logic [1:0]       sync_b;      // second synchronizer stage
  logic [1:0]       filt;        // filtered line levels
  logic             filt_clk_d;  // filtered clock one cycle late
  logic [FLT_W-1:0] flt_cnt [2];

  logic       clk_fall;
  logic       dat_f;
  ps2_state_e state;
  logic [2:0] bit_cnt;
  logic [10:0] stall_cnt;      // cycles since last clock edge in a frame
  scan_code_t shift;
  logic       par_ok;

  // both lines idle high
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_a     <= 2'b11;
      sync_b     <= 2'b11;
      filt       <= 2'b11;
      filt_clk_d <= 1'b1;
      for (int i = 0; i < 2; i++) begin
        flt_cnt[i] <= '0;
      end
    end else begin
      sync_a     <= {ps2_data, ps2_clk};
      sync_b     <= sync_a;
      filt_clk_d <= filt[LN_CLK];
      for (int i = 0; i < 2; i++) begin
        if (sync_b[i] == filt[i]) begin
          flt_cnt[i] <= '0;                         // run broken
        end else if (flt_cnt[i] == FLT_W'(`KBD_FILTER_LEN - 1)) begin
          filt[i]    <= sync_b[i];                  // enough equal samples
          flt_cnt[i] <= '0;
        end else begin
          flt_cnt[i] <= flt_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign clk_fall = filt_clk_d & ~filt[LN_CLK];
  assign dat_f    = filt[LN_DAT];

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      bit_cnt    <= '0;
      stall_cnt  <= '0;
      code_valid <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      code_valid <= 1'b0;
      frame_err  <= 1'b0;
      if (state == ST_IDLE || clk_fall) begin
        stall_cnt <= '0;
      end else begin
        stall_cnt <= stall_cnt + 1'b1;
      end
      if (stall_cnt[10]) begin
        state <= ST_IDLE;                           // stalled frame dropped silently
      end else if (clk_fall) begin
        case (state)
          ST_IDLE: begin
            bit_cnt <= '0;
            if (!dat_f) begin
              state <= ST_DATA;                     // low start bit
            end else begin
              frame_err <= 1'b1;
            end
          end
          ST_DATA: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= ST_PARITY;
            end
          end
          ST_PARITY: state <= ST_STOP;
          ST_STOP: begin
            state <= ST_IDLE;
            if (dat_f && par_ok) begin
              code_valid <= 1'b1;
            end else begin
              frame_err <= 1'b1;                    // parity or stop bit wrong
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // payload path with lsb first
  always_ff @(posedge clk) begin
    if (clk_fall && state == ST_DATA) begin
      shift <= {dat_f, shift[7:1]};
    end
    if (clk_fall && state == ST_PARITY) begin
      par_ok <= ^{shift, dat_f};                    // odd count of ones
    end
  end

  assign code = shift;

endmodule

`default_nettype wire

/* hdl/scan_fifo.sv */
//**************************************************************************
// scan_fifo: circular buffer of received scan codes, sticky overflow flag
//**************************************************************************

`default_nettype none

`include "kbd_config.svh"

module scan_fifo (
  input wire                 clk,
  input wire                 rst,
  input wire                 code_valid,
  input wire kbd_pkg::scan_code_t code,
  scan_fifo_if.producer      rd
);
  import kbd_pkg::*;

  localparam int DEPTH = 1 << `KBD_FIFO_LOG2;

  scan_code_t                mem [DEPTH];
  logic [`KBD_FIFO_LOG2-1:0] wr_ptr;
  logic [`KBD_FIFO_LOG2-1:0] rd_ptr;
  fifo_count_t               count;
  logic                      full;
  logic                      do_push;
  logic                      do_pop;

  assign full    = (count == fifo_count_t'(DEPTH));
  assign do_pop  = rd.pop && (count != '0);
  assign do_push = code_valid && (!full || do_pop);  // a pop frees the slot

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      rd.overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;                      // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // new loss wins over a clear in the same cycle
      if (code_valid && !do_push) begin
        rd.overflow <= 1'b1;
      end else if (rd.clear_ovf) begin
        rd.overflow <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= code;
    end
  end

  assign rd.code      = mem[rd_ptr];
  assign rd.not_empty = (count != '0);

endmodule

`default_nettype wire

/* hdl/kbd_regs.sv */
//**************************************************************************
// kbd_regs: cpu bus register block, status at address 0 and scan-code
// data at address 1, with acknowledge and level interrupt
//**************************************************************************

`default_nettype none

module kbd_regs (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    stb,
  input  wire                    we,
  input  wire                    addr,
  input  wire kbd_pkg::bus_data_t data_in,
  output kbd_pkg::bus_data_t     data_out,
  output logic                   ack,
  output logic                   irq,
  input  wire                    frame_err,
  scan_fifo_if.consumer          rd
);
  import kbd_pkg::*;

  localparam logic ADDR_STATUS = 1'b0;
  localparam logic ADDR_DATA   = 1'b1;

  logic       ien;         // interrupt enable
  logic       err;         // sticky frame error
  logic [3:0] scratch;     // free bits 7:4 for software
  logic       wr_status;
  logic       rd_data;
  bus_data_t  status;

  assign wr_status = stb && we && (addr == ADDR_STATUS);
  assign rd_data   = stb && !we && (addr == ADDR_DATA);

  always_ff @(posedge clk) begin
    if (rst) begin
      ien     <= 1'b0;
      err     <= 1'b0;
      scratch <= 4'h0;
    end else begin
      if (wr_status) begin
        ien     <= data_in[1];
        scratch <= data_in[7:4];
      end
      // a fresh error takes priority over the software clear
      if (frame_err) begin
        err <= 1'b1;
      end else if (wr_status && !data_in[2]) begin
        err <= 1'b0;
      end
    end
  end

  // overflow itself lives in the fifo, cleared at the write edge
  assign rd.clear_ovf = wr_status && !data_in[3];

  // one pop per cycle of stb, never on an empty fifo
  assign rd.pop = rd_data && rd.not_empty;

  // bit 0 is always the live fifo state, writes to it have no effect
  assign status = {scratch, rd.overflow, err, ien, rd.not_empty};

  always_comb begin
    if (addr == ADDR_DATA) begin
      data_out = bus_data_t'(rd.code);
    end else begin
      data_out = status;
    end
  end

  assign ack = stb;                                   // zero wait states
  assign irq = ien && rd.not_empty;

endmodule

`default_nettype wire

/* hdl/kbd_top.sv */
//**************************************************************************
// kbd_top: PS/2 keyboard controller, receiver + fifo + bus registers
//**************************************************************************

`default_nettype none

module kbd_top (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    ps2_clk,
  input  wire                    ps2_data,
  input  wire                    stb,
  input  wire                    we,
  input  wire                    addr,
  input  wire kbd_pkg::bus_data_t data_in,
  output kbd_pkg::bus_data_t     data_out,
  output logic                   ack,
  output logic                   irq
);
  import kbd_pkg::*;

  logic       rx_valid;    // good frame strobe
  scan_code_t rx_code;
  logic       rx_err;      // bad start, parity or stop

  scan_fifo_if fifo_bus ();

  ps2_rx u_rx (
    .clk        (clk),
    .rst        (rst),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .code_valid (rx_valid),
    .code       (rx_code),
    .frame_err  (rx_err)
  );

  scan_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .code_valid (rx_valid),
    .code       (rx_code),
    .rd         (fifo_bus.producer)
  );

  kbd_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .stb        (stb),
    .we         (we),
    .addr       (addr),
    .data_in    (data_in),
    .data_out   (data_out),
    .ack        (ack),
    .irq        (irq),
    .frame_err  (rx_err),
    .rd         (fifo_bus.consumer)
  );

endmodule

`default_nettype wire

/* sim/kbd_tb.sv */
//**************************************************************************
// kbd_tb: testbench with PS/2 frame driver, bus access, typed compares
//**************************************************************************

`default_nettype none

`include "kbd_config.svh"

module kbd_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import kbd_pkg::*;

  localparam int DEPTH    = 1 << `KBD_FIFO_LOG2;
  localparam int HALF_BIT = 20;                    // system clocks per ps2 half bit
  localparam int MAX_PATS = 64;
  localparam int EXTRA    = 2;                     // irq frames beyond the file

  logic        clk = 1'b0;
  logic        rst;
  logic        ps2_clk;
  logic        ps2_data;
  logic        stb;
  logic        we;
  logic        addr;
  bus_data_t   data_in;
  bus_data_t   data_out;
  logic        ack;
  logic        irq;

  logic [23:0] pats [MAX_PATS];                    // {status, group end, parity ok, code}
  scan_code_t  model_q [$];                        // codes the fifo should hold
  logic [31:0] rng = 32'd90;
  longint      wd_ns = 0;
  int          n_pat;
  int          errors = 0;
  int          checks = 0;

  kbd_top dut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_code(input string what, input scan_code_t exp, input scan_code_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0.1f ns: %s expected %h got %h", $realtime, what, exp, got);
    end
  endtask

  task automatic check_status(input string what, input bus_data_t exp, input bus_data_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0.1f ns: %s expected %h got %h", $realtime, what, exp, got);
    end
  endtask

  task automatic verify_flag(input string what, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0.1f ns: %s expected %b got %b", $realtime, what, exp, got);
    end
  endtask

  // one 11-bit frame, data changes while the clock is high
  task automatic send_frame(input scan_code_t code, input logic par_good);
    logic [10:0] bits;
    logic        par;
    par = ~^code;                                  // odd parity over data and parity
    if (!par_good) begin
      par = ~par;
    end
    bits = {1'b1, par, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(posedge clk);
      ps2_data <= bits[i];
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b0;                             // keyboard pulls clock low
      repeat (HALF_BIT) @(posedge clk);
      ps2_clk <= 1'b1;
    end
  endtask

  task automatic access_bus(input logic wr, input logic a, input bus_data_t wdata,
                            output bus_data_t rdata);
    @(posedge clk);
    stb     <= 1'b1;
    we      <= wr;
    addr    <= a;
    data_in <= wdata;
    @(negedge clk);
    rdata = data_out;                              // stable mid-cycle
    verify_flag("ack during access", 1'b1, ack);
    @(posedge clk);
    stb <= 1'b0;
    we  <= 1'b0;
    @(negedge clk);
    verify_flag("ack after access", 1'b0, ack);
  endtask

  task automatic drain_fifo();
    bus_data_t d;
    while (model_q.size() > 0) begin
      access_bus(1'b0, 1'b1, '0, d);
      check_code("data register", model_q.pop_front(), d);
    end
  endtask

  initial begin
    bus_data_t   st;
    bus_data_t   exp;
    logic [23:0] p;
    int          polls;
    rst      <= 1'b1;
    ps2_clk  <= 1'b1;                              // both lines idle high
    ps2_data <= 1'b1;
    stb      <= 1'b0;
    we       <= 1'b0;
    addr     <= 1'b0;
    data_in  <= '0;
    for (int i = 0; i < MAX_PATS; i++) begin
      pats[i] = '1;                                // marks unused slots
    end
    $readmemh("sim/kbd_patterns.txt", pats);
    n_pat = 0;
    while (n_pat < MAX_PATS && pats[n_pat] !== '1) begin
      n_pat++;
    end
    wd_ns = longint'(n_pat + EXTRA) * (22 * HALF_BIT * 8 + 2000) + 20000;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    verify_flag("irq after reset", 1'b0, irq);
    access_bus(1'b0, 1'b0, '0, st);
    check_status("status after reset", '0, st);

    for (int i = 0; i < n_pat; i++) begin
      p   = pats[i];
      rng = xorshift32(rng);
      repeat (10 + int'(rng[4:0])) @(posedge clk);  // random gap between frames
      send_frame(p[7:0], p[8]);
      if (p[8] && model_q.size() < DEPTH) begin
        model_q.push_back(p[7:0]);                 // full fifo drops the code
      end
      if (p[12]) begin
        exp   = bus_data_t'(p[23:16]);
        st    = '0;
        polls = 0;
        while (exp[0] && !st[0] && polls < 100) begin
          access_bus(1'b0, 1'b0, '0, st);
          polls++;
        end
        if (exp[0] && !st[0]) begin
          errors++;
          $display("ready bit never came up after %0d status polls", polls);
        end
        access_bus(1'b0, 1'b0, '0, st);
        check_status("status after group", exp, st);
        verify_flag("irq with ien low", 1'b0, irq);
        drain_fifo();
        access_bus(1'b0, 1'b0, '0, st);
        check_status("status after drain", exp & ~bus_data_t'(1), st);
        access_bus(1'b1, 1'b0, '0, st);            // bits 3:2 low clear ovf and err
        access_bus(1'b0, 1'b0, '0, st);
        check_status("status after clear", '0, st);
      end
    end

    // interrupt follows ien and the fifo level
    for (int k = 0; k < EXTRA; k++) begin
      rng = xorshift32(rng);
      send_frame(rng[15:8], 1'b1);
      model_q.push_back(rng[15:8]);
    end
    access_bus(1'b0, 1'b0, '0, st);
    check_status("status with two codes", bus_data_t'(1), st);
    verify_flag("irq with ien low", 1'b0, irq);
    access_bus(1'b1, 1'b0, bus_data_t'(2), st);    // ien on
    verify_flag("irq with ien high", 1'b1, irq);
    access_bus(1'b0, 1'b1, '0, st);
    check_code("data register", model_q.pop_front(), st);
    verify_flag("irq with one code left", 1'b1, irq);
    access_bus(1'b0, 1'b1, '0, st);
    check_code("data register", model_q.pop_front(), st);
    verify_flag("irq after last read", 1'b0, irq);

    for (int k = 0; k < 4; k++) begin
      rng = xorshift32(rng);
      access_bus(1'b1, 1'b0, {rng[7:4], 2'b00, rng[1], k[0]}, st);  // bit 0 must not stick
      access_bus(1'b0, 1'b0, '0, st);
      check_status("scratch and ien readback", {rng[7:4], 2'b00, rng[1], 1'b0}, st);
    end

    $display("kbd_tb finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // limit scales with the number of frames sent
  initial begin
    wait (wd_ns > 0);
    #(wd_ns);
    $display("watchdog timeout, run did not finish within %0d ns", wd_ns);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hdl/kbd_pkg.sv
hdl/scan_fifo_if.sv
hdl/ps2_rx.sv
hdl/scan_fifo.sv
hdl/kbd_regs.sv
hdl/kbd_top.sv
sim/kbd_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the PS/2 keyboard controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
  --top-module kbd_tb -o kbd_sim -f all.f

./obj_dir/kbd_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "result: pass"
else
  echo "result: fail"
  exit 1
fi

/* sim/kbd_patterns.txt */
// one record per ps2 frame, a 24-bit hex word with these fields
// [23:16] expected status at group end, [15:12] group end, [11:8] parity good, [7:0] code
// single good codes, each read back on its own
01111C
011132
0111F0
// good code followed by a parity error
000123
05102B
// parity error alone
041045
// ten good codes without reads, two more than the fifo holds
000115
00011D
000124
00012D
00012C
000135
00013C
000143
000144
09114D
// good, bad, good
00010E
00005A
051066
